//--- Makefile
# Verilator flow for the beamforming combiner testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= bf_top_tb
FILELIST  ?= bf_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ns -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100000

FAIL_MSG  := Result: FAILED
PASS_MSG  := Result: PASSED
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation stopped without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bf_channel_summer.sv
`include "bf_defs.svh"

module bf_channel_summer import bf_pkg::*; (
    input  logic                         clock,
    input  logic                         resetn,
    input  logic                         advance,
    input  logic                         stage_valid,
    input  logic                         stage_last,
    input  lane_vec_t [`BF_CHANNELS-1:0] channels,
    output beam_out_t                    out_data,
    output logic                         out_valid
);

    // divide by the channel count is a right shift
    localparam int DIV_SHIFT = $clog2(`BF_CHANNELS);
    // guard bits so the four-way sum cannot wrap
    localparam int SUM_W = `BF_SAMPLE_W + DIV_SHIFT;
    // half of the divisor, for round half up
    localparam logic signed [SUM_W-1:0] ROUND_HALF = 1 << (DIV_SHIFT - 1);

    // averaged lanes before the output register
    lane_vec_t avg;

    // per lane, per part: sum, round, shift
    // the mean of in-range values stays in range, so no clamp
    always_comb begin
        logic signed [SUM_W-1:0] re_acc;
        logic signed [SUM_W-1:0] im_acc;
        for (int lane = 0; lane < `BF_LANES; lane++) begin
            re_acc = '0;
            im_acc = '0;
            // operands sign-extend into the guard bits
            for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
                re_acc = re_acc + channels[ch][lane].re;
                im_acc = im_acc + channels[ch][lane].im;
            end
            re_acc = re_acc + ROUND_HALF;
            im_acc = im_acc + ROUND_HALF;
            // dropping the low bits is the arithmetic shift
            avg[lane].re = re_acc[SUM_W-1:DIV_SHIFT];
            avg[lane].im = im_acc[SUM_W-1:DIV_SHIFT];
        end
    end

    // output valid follows stage one on every advance
    always_ff @(posedge clock) begin
        if (!resetn) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= stage_valid;
        end
    end

    // output payload, held stable while the sink stalls
    always_ff @(posedge clock) begin
        if (advance) begin
            out_data.lanes <= avg;
            out_data.last  <= stage_last;
        end
    end

endmodule

//--- bf_channel_weigher.sv
`include "bf_defs.svh"

module bf_channel_weigher import bf_pkg::*; (
    input  logic         clock,
    input  logic         resetn,
    input  logic         advance,
    input  cplx_weight_t weight_in,
    input  lane_vec_t    lanes_in,
    output lane_vec_t    lanes_out
);

    // channel weight, one pipeline stage ahead of the data
    cplx_weight_t weight_q;

    // combinational lane products
    lane_vec_t products;

    // weight register runs every cycle
    // a beat is weighted with the value seen one cycle before it is taken
    always_ff @(posedge clock) begin
        if (!resetn) begin
            weight_q <= '0;
        end else begin
            weight_q <= weight_in;
        end
    end

    // one multiplier per lane, all sharing the channel weight
    for (genvar lane = 0; lane < `BF_LANES; lane++) begin : g_lane
        bf_lane_mult u_lane_mult (
            .sample  (lanes_in[lane]),
            .weight  (weight_q),
            .product (products[lane])
        );
    end

    // stage one data register
    // holds on stall, valid is tracked in the top level
    always_ff @(posedge clock) begin
        if (advance) begin
            lanes_out <= products;
        end
    end

endmodule

//--- bf_defs.svh
`ifndef BF_DEFS_SVH
`define BF_DEFS_SVH

// widths and sizes shared by the whole combiner

// one real or imaginary sample, signed
`define BF_SAMPLE_W 16

// one part of a complex weight, signed Q1.7
`define BF_WEIGHT_W 8

// fraction bits of the weight format
// products are scaled back by this amount
`define BF_FRAC_W 7

// complex samples carried per beat and channel
`define BF_LANES 8

// antenna channels summed into one beam
// the final divide is a shift by log2 of this
`define BF_CHANNELS 4

`endif

//--- bf_lane_mult.sv
`include "bf_defs.svh"

module bf_lane_mult import bf_pkg::*; (
    input  cplx_sample_t sample,
    input  cplx_weight_t weight,
    output cplx_sample_t product
);

    // full product width plus one bit for the sum of two products
    localparam int PROD_W = `BF_SAMPLE_W + `BF_WEIGHT_W + 1;
    // width left after dropping the fraction bits
    localparam int SHIFT_W = PROD_W - `BF_FRAC_W;

    // half an lsb of the Q1.7 scale sits at bit 6
    localparam logic signed [PROD_W-1:0] ROUND_HALF = 1 << (`BF_FRAC_W - 1);

    // clamp limits of the signed sample range
    localparam logic signed [SHIFT_W-1:0] SAT_MAX = (2 ** (`BF_SAMPLE_W - 1)) - 1;
    localparam logic signed [SHIFT_W-1:0] SAT_MIN = -SAT_MAX - 1;

    logic signed [PROD_W-1:0] re_full;
    logic signed [PROD_W-1:0] im_full;

    // round half up, drop fraction, then clamp
    function automatic sample_t round_sat(input logic signed [PROD_W-1:0] full);
        logic signed [PROD_W-1:0]  rounded;
        logic signed [SHIFT_W-1:0] scaled;
        rounded = full + ROUND_HALF;
        // slice is the arithmetic shift by the fraction width
        scaled = rounded[PROD_W-1:`BF_FRAC_W];
        if (scaled > SAT_MAX) begin
            return SAT_MAX[`BF_SAMPLE_W-1:0];
        end
        if (scaled < SAT_MIN) begin
            return SAT_MIN[`BF_SAMPLE_W-1:0];
        end
        return scaled[`BF_SAMPLE_W-1:0];
    endfunction

    // true complex multiply at full width
    // re = wr*xr - wi*xi
    // im = wr*xi + wi*xr
    always_comb begin
        re_full = weight.re * sample.re - weight.im * sample.im;
        im_full = weight.re * sample.im + weight.im * sample.re;
    end

    // large weights on samples near the rails reach the clamp
    assign product.re = round_sat(re_full);
    assign product.im = round_sat(im_full);

endmodule

//--- bf_pkg.sv
`include "bf_defs.svh"

package bf_pkg;

    // one signed sample, real or imaginary
    typedef logic signed [`BF_SAMPLE_W-1:0] sample_t;

    // complex sample, re sits in the upper half
    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_sample_t;

    // complex weight in Q1.7
    // 0x40 is 0.5, 0x80 is -1.0
    typedef struct packed {
        logic signed [`BF_WEIGHT_W-1:0] re;
        logic signed [`BF_WEIGHT_W-1:0] im;
    } cplx_weight_t;

    // all lanes of one channel in one beat
    typedef cplx_sample_t [`BF_LANES-1:0] lane_vec_t;

    // input beat, every channel plus the last flag
    typedef struct packed {
        lane_vec_t [`BF_CHANNELS-1:0] chan;
        logic                         last;
    } beam_in_t;

    // combined output beat
    typedef struct packed {
        lane_vec_t lanes;
        logic      last;
    } beam_out_t;

    // one weight per channel
    typedef cplx_weight_t [`BF_CHANNELS-1:0] weight_set_t;

endpackage

//--- bf_top.f
+incdir+.
bf_pkg.sv
bf_lane_mult.sv
bf_channel_weigher.sv
bf_channel_summer.sv
bf_top.sv
bf_top_asserts.sv
bf_top_tb.sv

//--- bf_top.sv
`include "bf_defs.svh"

module bf_top import bf_pkg::*; (
    input  logic        clock,
    input  logic        resetn,
    input  beam_in_t    in_data,
    input  logic        in_valid,
    output logic        in_ready,
    input  weight_set_t weights,
    output beam_out_t   out_data,
    output logic        out_valid,
    input  logic        out_ready
);

    // whole pipeline moves together
    logic advance;

    // stage one control, data sits in the weighers
    logic stage_valid;
    logic stage_last;

    // weighted lanes of every channel
    lane_vec_t [`BF_CHANNELS-1:0] weighted;

    // move when the sink takes the beat or the output slot is empty
    assign advance  = out_ready || !out_valid;
    assign in_ready = advance;

    // stage one valid, a bubble enters when no beat is offered
    always_ff @(posedge clock) begin
        if (!resetn) begin
            stage_valid <= 1'b0;
        end else if (advance) begin
            stage_valid <= in_valid;
        end
    end

    // last rides along with the stage one data
    always_ff @(posedge clock) begin
        if (advance) begin
            stage_last <= in_data.last;
        end
    end

    // one weigher per antenna channel
    for (genvar ch = 0; ch < `BF_CHANNELS; ch++) begin : g_chan
        bf_channel_weigher u_weigher (
            .clock     (clock),
            .resetn    (resetn),
            .advance   (advance),
            .weight_in (weights[ch]),
            .lanes_in  (in_data.chan[ch]),
            .lanes_out (weighted[ch])
        );
    end

    // combine, average and register the output beat
    bf_channel_summer u_summer (
        .clock       (clock),
        .resetn      (resetn),
        .advance     (advance),
        .stage_valid (stage_valid),
        .stage_last  (stage_last),
        .channels    (weighted),
        .out_data    (out_data),
        .out_valid   (out_valid)
    );

endmodule

//--- bf_top_asserts.sv
`include "bf_defs.svh"

module bf_top_asserts import bf_pkg::*; (
    input logic        clock,
    input logic        resetn,
    input beam_in_t    in_data,
    input logic        in_valid,
    input logic        in_ready,
    input weight_set_t weights,
    input beam_out_t   out_data,
    input logic        out_valid,
    input logic        out_ready
);

    timeunit 1ns;
    timeprecision 1ns;

    // signed sample rails
    localparam int SAT_HI = (1 << (`BF_SAMPLE_W - 1)) - 1;
    localparam int SAT_LO = -(1 << (`BF_SAMPLE_W - 1));
    // half an lsb at the Q1.7 scale
    localparam int ROUND_W = 1 << (`BF_FRAC_W - 1);
    // channel average is a shift
    localparam int AVG_SHIFT = $clog2(`BF_CHANNELS);

    // read by the testbench at the end of the run
    int unsigned fail_count = 0;

    // weights as the DUT sees them, one cycle late
    weight_set_t w_prev;

    // shadow of the two pipeline stages
    logic      s1_valid;
    logic      s2_valid;
    beam_out_t s1_beat;
    beam_out_t s2_beat;
    logic      model_advance;

    // output one edge back, for the stall check
    beam_out_t out_prev;

    // rounded and clamped value of one full product
    function automatic int scale_part(input longint full);
        longint v;
        v = (full + ROUND_W) >>> `BF_FRAC_W;
        if (v > SAT_HI) begin
            return SAT_HI;
        end
        if (v < SAT_LO) begin
            return SAT_LO;
        end
        return int'(v);
    endfunction

    // combined beat for one input beat and one weight set
    function automatic beam_out_t expected_beat(input beam_in_t beat, input weight_set_t w);
        beam_out_t res;
        longint    wr;
        longint    wi;
        longint    xr;
        longint    xi;
        int        sum_re;
        int        sum_im;
        res.last = beat.last;
        for (int l = 0; l < `BF_LANES; l++) begin
            sum_re = 0;
            sum_im = 0;
            for (int c = 0; c < `BF_CHANNELS; c++) begin
                wr = w[c].re;
                wi = w[c].im;
                xr = beat.chan[c][l].re;
                xi = beat.chan[c][l].im;
                sum_re += scale_part(wr * xr - wi * xi);
                sum_im += scale_part(wr * xi + wi * xr);
            end
            // mean over channels, round half up
            res.lanes[l].re = sample_t'((sum_re + (1 << (AVG_SHIFT - 1))) >>> AVG_SHIFT);
            res.lanes[l].im = sample_t'((sum_im + (1 << (AVG_SHIFT - 1))) >>> AVG_SHIFT);
        end
        return res;
    endfunction

    // stall only when the shadow output slot is full and the sink waits
    assign model_advance = out_ready || !s2_valid;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            w_prev   <= '0;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            w_prev <= weights;
            if (model_advance) begin
                s1_valid <= in_valid;
                s1_beat  <= expected_beat(in_data, w_prev);
                s2_valid <= s1_valid;
                s2_beat  <= s1_beat;
            end
        end
    end

    always_ff @(posedge clock) begin
        out_prev <= out_data;
    end

    // quiet right after any reset edge
    a_reset_quiet: assert property (@(posedge clock) !resetn |=> !out_valid)
    else begin
        fail_count++;
        $error("out_valid was high on the cycle after a reset edge at %0t", $time);
    end

    a_valid_model: assert property (@(posedge clock) disable iff (!resetn)
        out_valid == s2_valid)
    else begin
        fail_count++;
        $error("MISMATCH %0t out_valid expected %0b actual %0b",
               $time, $sampled(s2_valid), $sampled(out_valid));
    end

    a_no_spurious: assert property (@(posedge clock) disable iff (!resetn)
        $rose(out_valid) |-> s2_valid)
    else begin
        fail_count++;
        $error("out_valid rose without an input beat two advances earlier at %0t", $time);
    end

    a_in_ready: assert property (@(posedge clock) disable iff (!resetn)
        in_ready == model_advance)
    else begin
        fail_count++;
        $error("MISMATCH %0t in_ready expected %0b actual %0b",
               $time, $sampled(model_advance), $sampled(in_ready));
    end

    // back-pressure keeps the beat in place
    a_stall_ready: assert property (@(posedge clock) disable iff (!resetn)
        (out_valid && !out_ready) |-> !in_ready)
    else begin
        fail_count++;
        $error("in_ready was high while the sink stalled a valid beat at %0t", $time);
    end

    a_stall_valid: assert property (@(posedge clock) disable iff (!resetn)
        (out_valid && !out_ready) |=> out_valid)
    else begin
        fail_count++;
        $error("MISMATCH %0t out_valid expected 1 actual %0b", $time, $sampled(out_valid));
    end

    a_stall_data: assert property (@(posedge clock) disable iff (!resetn)
        (out_valid && !out_ready) |=> out_data == out_prev)
    else begin
        fail_count++;
        $error("MISMATCH %0t out_data expected %h actual %h",
               $time, $sampled(out_prev), $sampled(out_data));
    end

    a_last: assert property (@(posedge clock) disable iff (!resetn)
        out_valid |-> out_data.last == s2_beat.last)
    else begin
        fail_count++;
        $error("MISMATCH %0t out_data.last expected %0b actual %0b",
               $time, $sampled(s2_beat.last), $sampled(out_data.last));
    end

    // per lane value checks
    for (genvar l = 0; l < `BF_LANES; l++) begin : g_lane_check
        a_lane_re: assert property (@(posedge clock) disable iff (!resetn)
            out_valid |-> out_data.lanes[l].re == s2_beat.lanes[l].re)
        else begin
            fail_count++;
            $error("MISMATCH %0t out_data.lanes[%0d].re expected %0d actual %0d",
                   $time, l, $sampled(s2_beat.lanes[l].re), $sampled(out_data.lanes[l].re));
        end

        a_lane_im: assert property (@(posedge clock) disable iff (!resetn)
            out_valid |-> out_data.lanes[l].im == s2_beat.lanes[l].im)
        else begin
            fail_count++;
            $error("MISMATCH %0t out_data.lanes[%0d].im expected %0d actual %0d",
                   $time, l, $sampled(s2_beat.lanes[l].im), $sampled(out_data.lanes[l].im));
        end
    end

endmodule

bind bf_top bf_top_asserts u_asserts (
    .clock     (clock),
    .resetn    (resetn),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .weights   (weights),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

//--- bf_top_tb.sv
`include "bf_defs.svh"

module bf_top_tb import bf_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ns;

    // cycles any single wait may take
    localparam int WAIT_LIMIT = 200;
    localparam logic [31:0] SEED = 32'hfdf42c41;

    logic        clock;
    logic        resetn;
    beam_in_t    in_data;
    logic        in_valid;
    logic        in_ready;
    weight_set_t weights;
    beam_out_t   out_data;
    logic        out_valid;
    logic        out_ready;

    // separate streams so the two drivers never share state
    logic [31:0] data_state;
    logic [31:0] ready_state;
    // random out_ready when set and held high otherwise
    logic        stall_random;

    int sent_count;
    int recv_count;
    int timeouts;
    int total_errors;

    bf_top u_dut (
        .clock     (clock),
        .resetn    (resetn),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .weights   (weights),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_data_rand();
        data_state = xorshift(data_state);
        return data_state;
    endfunction

    // 0.5, -1.0 and zero show up often on purpose
    function automatic logic [7:0] weight_part(input logic [2:0] pick, input logic [7:0] raw);
        case (pick)
            3'd0: return 8'h40;
            3'd1: return 8'h80;
            3'd2: return 8'h00;
            default: return raw;
        endcase
    endfunction

    // samples at or next to the rails
    function automatic sample_t rail_value(input logic [1:0] pick);
        case (pick)
            2'd0: return 16'h7fff;
            2'd1: return 16'h7ffe;
            2'd2: return 16'h8001;
            default: return 16'h8000;
        endcase
    endfunction

    // one 32-bit draw fills one complex sample
    function automatic beam_in_t random_beat();
        beam_in_t    beat;
        logic [31:0] r;
        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            for (int lane = 0; lane < `BF_LANES; lane++) begin
                beat.chan[ch][lane] = next_data_rand();
            end
        end
        r = next_data_rand();
        beat.last = r[0];
        return beat;
    endfunction

    function automatic beam_in_t rail_beat();
        beam_in_t    beat;
        logic [31:0] r;
        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            for (int lane = 0; lane < `BF_LANES; lane++) begin
                r = next_data_rand();
                beat.chan[ch][lane].re = rail_value(r[1:0]);
                beat.chan[ch][lane].im = rail_value(r[3:2]);
            end
        end
        beat.last = r[4];
        return beat;
    endfunction

    // pin_corners forces 0.5 and -1.0 onto the first two channels
    task automatic load_random_weights(input bit pin_corners);
        weight_set_t next_set;
        logic [31:0] r;
        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            r = next_data_rand();
            next_set[ch].re = weight_part(r[2:0], r[15:8]);
            next_set[ch].im = weight_part(r[5:3], r[23:16]);
        end
        if (pin_corners) begin
            next_set[0].re = 8'h40;
            next_set[0].im = 8'h00;
            next_set[1].re = 8'h80;
            next_set[1].im = 8'h40;
        end
        weights <= next_set;
    endtask

    // -1.0 real with a large imaginary part drives products into the clamp
    task automatic load_rail_weights();
        weight_set_t next_set;
        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            next_set[ch].re = 8'h80;
            next_set[ch].im = ch[0] ? 8'h7f : 8'h80;
        end
        weights <= next_set;
    endtask

    task automatic idle_cycles(input int n);
        in_valid <= 1'b0;
        repeat (n) @(posedge clock);
    endtask

    // offer one beat and return on the edge that takes it
    task automatic send_beat(input beam_in_t beat);
        int waited;
        waited = 0;
        in_data  <= beat;
        in_valid <= 1'b1;
        @(negedge clock);
        while (!in_ready && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clock);
        end
        if (in_ready) begin
            sent_count++;
        end else begin
            timeouts++;
            $display("timeout: in_ready stayed low for %0d cycles at %0t", WAIT_LIMIT, $time);
        end
        @(posedge clock);
    endtask

    task automatic send_burst(input int count, input bit rails, input bit gaps);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            if (gaps) begin
                r = next_data_rand();
                if (r[1:0] == 2'd0) begin
                    idle_cycles(1 + r[2]);
                end
            end
            send_beat(rails ? rail_beat() : random_beat());
        end
        in_valid <= 1'b0;
    endtask

    // until every accepted beat has left the DUT
    task automatic wait_drain();
        int waited;
        waited = 0;
        @(posedge clock);
        while (recv_count != sent_count && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clock);
        end
        if (recv_count != sent_count) begin
            timeouts++;
            $display("timeout: only %0d of %0d beats came out by %0t",
                     recv_count, sent_count, $time);
        end
    endtask

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    // sink side with random stalls when enabled
    initial begin
        ready_state = ~SEED;
        forever begin
            @(posedge clock);
            ready_state = xorshift(ready_state);
            out_ready <= stall_random ? ready_state[16] : 1'b1;
        end
    end

    // output transfer seen half a cycle before its edge
    always @(negedge clock) begin
        if (resetn && out_valid && out_ready) begin
            recv_count++;
        end
    end

    initial begin
        resetn       = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        weights      = '0;
        out_ready    = 1'b0;
        stall_random = 1'b0;
        data_state   = SEED;
        sent_count   = 0;
        recv_count   = 0;
        timeouts     = 0;

        repeat (3) @(posedge clock);
        resetn <= 1'b1;

        // streaming with the sink always ready
        load_random_weights(1'b1);
        idle_cycles(2);
        send_burst(24, 1'b0, 1'b0);

        // random weights under back-pressure
        stall_random <= 1'b1;
        idle_cycles(2);
        load_random_weights(1'b0);
        idle_cycles(2);
        send_burst(40, 1'b0, 1'b1);

        // rail samples into the clamp
        idle_cycles(2);
        load_rail_weights();
        idle_cycles(2);
        send_burst(16, 1'b1, 1'b1);

        stall_random <= 1'b0;
        wait_drain();
        idle_cycles(4);

        total_errors = u_dut.u_asserts.fail_count + timeouts;
        $display("done: %0d assertion failures, %0d timeouts, %0d beats in, %0d beats out",
                 u_dut.u_asserts.fail_count, timeouts, sent_count, recv_count);
        if (total_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
